// ==== include/spi_defs.svh ====
`ifndef SPI_DEFS_SVH
`define SPI_DEFS_SVH

////////////////////////////////////////
// Frame layout
////////////////////////////////////////

// One rw bit, then address, then data
`define SPI_FRAME_W 32
`define SPI_ADDR_W 7
`define SPI_DATA_W 24

////////////////////////////////////////
// SPI clock
////////////////////////////////////////

// CLK50MHZ cycles per SPI half period, 12.5 MHz SCK
`define SPI_HALF_DIV 2

`endif

// ==== design/spi_pkg.sv ====
`include "spi_defs.svh"

package spi_pkg;

	// One frame on the wire, rw goes out first
	typedef struct packed {
		logic                   rw;
		logic [`SPI_ADDR_W-1:0] addr;
		logic [`SPI_DATA_W-1:0] data;
	} spi_frame_t;

	// Shifter FSM states
	typedef enum logic [1:0] {
		trig_waiting = 2'd0,
		sending      = 2'd1,
		done         = 2'd2
	} spi_state_e;

	// 1 means write
	localparam logic RW_WRITE = 1'b1;

endpackage

// ==== design/spi_tick_if.sv ====
`timescale 1ns/1ps

// SPI clock phase and shift strobes between divider and shifter
interface spi_tick_if;

	logic run;
	logic sck_level;
	logic write_trig;
	logic read_trig;

	modport gen (
		input  run,
		output sck_level,
		output write_trig,
		output read_trig
	);

	modport master (
		output run,
		input  sck_level,
		input  write_trig,
		input  read_trig
	);

endinterface

// ==== design/spi_clk_gen.sv ====
`timescale 1ns/1ps
`include "spi_defs.svh"

module spi_clk_gen #(
	parameter int HALF_DIV = `SPI_HALF_DIV
) (
	input  logic    CLK50MHZ,
	input  logic    RST,
	spi_tick_if.gen tick
);

	localparam int CNT_W = $clog2(HALF_DIV + 1);

	logic [CNT_W-1:0] div_cnt;
	logic             lead;
	logic             half_end;

	// Last system cycle of the current half period
	assign half_end = (div_cnt == CNT_W'(HALF_DIV - 1));

	////////////////////////////////////////
	// Divider and strobes
	////////////////////////////////////////

	// The first half period after run rises is a low lead-in. It ends with
	// a write strobe so MOSI is set up before the first rising edge.
	always_ff @(posedge CLK50MHZ) begin
		if (RST || !tick.run) begin
			div_cnt         <= '0;
			lead            <= 1'b1;
			tick.sck_level  <= 1'b0;
			tick.write_trig <= 1'b0;
			tick.read_trig  <= 1'b0;
		end else begin
			tick.write_trig <= 1'b0;
			tick.read_trig  <= 1'b0;
			if (half_end) begin
				div_cnt <= '0;
				if (lead) begin
					lead            <= 1'b0;
					tick.write_trig <= 1'b1;
				end else begin
					tick.sck_level <= !tick.sck_level;
					// Low to high samples, high to low shifts
					tick.read_trig  <= !tick.sck_level;
					tick.write_trig <= tick.sck_level;
				end
			end else begin
				div_cnt <= div_cnt + 1'b1;
			end
		end
	end

endmodule

// ==== design/spi_master.sv ====
`timescale 1ns/1ps
`include "spi_defs.svh"

module spi_master
	import spi_pkg::*;
#(
	parameter int WIDTH = `SPI_FRAME_W
) (
	input  logic             CLK50MHZ,
	input  logic             RST,
	input  logic             spi_trig,
	input  logic [WIDTH-1:0] tx_frame,
	output logic [WIDTH-1:0] rx_frame,
	output logic             spi_done,
	output logic             spi_sck,
	output logic             spi_cs,
	output logic             spi_mosi,
	input  logic             spi_miso,
	spi_tick_if.master       tick
);

	localparam int IDX_W = $clog2(WIDTH + 1);

	spi_state_e       state;
	logic [IDX_W-1:0] bit_idx;
	logic [WIDTH-1:0] shift_out;
	logic [WIDTH-1:0] shift_in;
	logic             shift_edge;
	logic             last_edge;
	logic             sck_window;

	// Falling edge after the last bit closes the frame
	assign last_edge  = tick.write_trig && (bit_idx == IDX_W'(WIDTH));
	assign shift_edge = tick.write_trig && !last_edge;

	// Index 0 is the lead-in before the first bit
	assign sck_window = (state == sending) && (bit_idx != '0);

	////////////////////////////////////////
	// FSM
	////////////////////////////////////////

	always_ff @(posedge CLK50MHZ) begin
		if (RST) begin
			state <= trig_waiting;
		end else begin
			case (state)
				trig_waiting:
					if (spi_trig)
						state <= sending;
				sending:
					if (last_edge)
						state <= done;
				default:
					state <= trig_waiting;
			endcase
		end
	end

	// Bit counter advances on each write strobe
	always_ff @(posedge CLK50MHZ) begin
		if (RST) begin
			bit_idx <= '0;
		end else if (state == sending) begin
			if (shift_edge)
				bit_idx <= bit_idx + 1'b1;
		end else begin
			bit_idx <= '0;
		end
	end

	////////////////////////////////////////
	// Shift registers
	////////////////////////////////////////

	// Tx frame is reloaded every idle cycle, so it is current at the trigger
	always_ff @(posedge CLK50MHZ) begin
		if (state == trig_waiting)
			shift_out <= tx_frame;
		else if (state == sending && shift_edge)
			shift_out <= {shift_out[WIDTH-2:0], 1'b0};
	end

	always_ff @(posedge CLK50MHZ) begin
		if (tick.read_trig && sck_window)
			shift_in <= {shift_in[WIDTH-2:0], spi_miso};
	end

	always_ff @(posedge CLK50MHZ) begin
		if (RST)
			spi_mosi <= 1'b0;
		else if (state != sending)
			spi_mosi <= 1'b0;
		else if (shift_edge)
			spi_mosi <= shift_out[WIDTH-1];
	end

	////////////////////////////////////////
	// Chip select and outputs
	////////////////////////////////////////

	// Rises together with the move to done
	always_ff @(posedge CLK50MHZ) begin
		if (RST)
			spi_cs <= 1'b1;
		else if (state == trig_waiting && spi_trig)
			spi_cs <= 1'b0;
		else if (state == sending && last_edge)
			spi_cs <= 1'b1;
	end

	assign spi_sck  = tick.sck_level && sck_window;
	assign spi_done = (state == done);
	assign rx_frame = shift_in;
	assign tick.run = (state == sending);

endmodule

// ==== design/spi_reg_access.sv ====
`timescale 1ns/1ps
`include "spi_defs.svh"

module spi_reg_access
	import spi_pkg::*;
(
	input  logic                   CLK50MHZ,
	input  logic                   RST,
	// Host side
	input  logic                   req,
	input  logic                   rw,
	input  logic [`SPI_ADDR_W-1:0] addr,
	input  logic [`SPI_DATA_W-1:0] wdata,
	output logic                   busy,
	output logic                   ack,
	output logic [`SPI_DATA_W-1:0] rdata,
	// Shifter side
	output logic                   spi_trig,
	output spi_frame_t             tx_frame,
	input  spi_frame_t             rx_frame,
	input  logic                   spi_done
);

	logic accept;

	// Requests while busy are simply lost
	assign accept = req && !busy;

	////////////////////////////////////////
	// Handshake
	////////////////////////////////////////

	always_ff @(posedge CLK50MHZ) begin
		if (RST) begin
			busy     <= 1'b0;
			ack      <= 1'b0;
			spi_trig <= 1'b0;
		end else begin
			spi_trig <= accept;
			ack      <= spi_done;
			if (accept)
				busy <= 1'b1;
			else if (spi_done)
				busy <= 1'b0;
		end
	end

	////////////////////////////////////////
	// Frame packing and read data
	////////////////////////////////////////

	// Held until the next accepted request, well past done
	always_ff @(posedge CLK50MHZ) begin
		if (accept) begin
			tx_frame.rw   <= rw;
			tx_frame.addr <= addr;
			// Reads send zeros in the data field
			tx_frame.data <= (rw == RW_WRITE) ? wdata : '0;
		end
	end

	always_ff @(posedge CLK50MHZ) begin
		if (spi_done)
			rdata <= rx_frame.data;
	end

endmodule

// ==== design/spi_reg_top.sv ====
`timescale 1ns/1ps
`include "spi_defs.svh"

module spi_reg_top
	import spi_pkg::*;
(
	input  logic                   CLK50MHZ,
	input  logic                   RST,
	// Host request port
	input  logic                   req,
	input  logic                   rw,
	input  logic [`SPI_ADDR_W-1:0] addr,
	input  logic [`SPI_DATA_W-1:0] wdata,
	output logic                   busy,
	output logic                   ack,
	output logic [`SPI_DATA_W-1:0] rdata,
	// SPI pins
	output logic                   spi_sck,
	output logic                   spi_cs,
	output logic                   spi_mosi,
	input  logic                   spi_miso
);

	spi_frame_t tx_frame;
	spi_frame_t rx_frame;
	logic       spi_trig;
	logic       spi_done;

	spi_tick_if tick ();

	spi_clk_gen #(
		.HALF_DIV (`SPI_HALF_DIV)
	) i_clk_gen (
		.CLK50MHZ (CLK50MHZ),
		.RST      (RST),
		.tick     (tick.gen)
	);

	spi_master #(
		.WIDTH (`SPI_FRAME_W)
	) i_master (
		.CLK50MHZ (CLK50MHZ),
		.RST      (RST),
		.spi_trig (spi_trig),
		.tx_frame (tx_frame),
		.rx_frame (rx_frame),
		.spi_done (spi_done),
		.spi_sck  (spi_sck),
		.spi_cs   (spi_cs),
		.spi_mosi (spi_mosi),
		.spi_miso (spi_miso),
		.tick     (tick.master)
	);

	spi_reg_access i_reg_access (
		.CLK50MHZ (CLK50MHZ),
		.RST      (RST),
		.req      (req),
		.rw       (rw),
		.addr     (addr),
		.wdata    (wdata),
		.busy     (busy),
		.ack      (ack),
		.rdata    (rdata),
		.spi_trig (spi_trig),
		.tx_frame (tx_frame),
		.rx_frame (rx_frame),
		.spi_done (spi_done)
	);

endmodule

// ==== verif/spi_slave_model.sv ====
`timescale 1ns/1ps
`include "spi_defs.svh"

// Mode 0 register-file SPI peripheral with one frame per cs-low window
module spi_slave_model
	import spi_pkg::*;
(
	input  logic       spi_sck,
	input  logic       spi_cs,
	input  logic       spi_mosi,
	output logic       spi_miso,
	// Seen by the testbench after each frame
	output spi_frame_t last_frame,
	output int         frame_count,
	output int         err_count
);

	localparam int NUM_REGS = 1 << `SPI_ADDR_W;
	localparam int HDR_W    = 1 + `SPI_ADDR_W;

	logic [`SPI_DATA_W-1:0]  regs [NUM_REGS];
	logic [`SPI_FRAME_W-1:0] shift;
	logic [`SPI_DATA_W-1:0]  rd_word;
	logic                    in_frame;
	int                      edge_cnt;
	realtime                 mosi_change_t;
	realtime                 sck_rise_t;

	initial begin
		for (int i = 0; i < NUM_REGS; i++)
			regs[i] = '0;
		spi_miso      = 1'b0;
		last_frame    = '0;
		frame_count   = 0;
		err_count     = 0;
		in_frame      = 1'b0;
		edge_cnt      = 0;
		shift         = '0;
		rd_word       = '0;
		mosi_change_t = 0.0;
		sck_rise_t    = -1.0;
	end

	// MOSI must not move in the time step of a rising SCK edge
	always @(spi_mosi) begin
		mosi_change_t = $realtime;
		if (spi_cs === 1'b0 && sck_rise_t == $realtime) begin
			$display("** Error at %0d ns: MOSI changed on a rising SCK edge", $time);
			err_count++;
		end
	end

	////////////////////////////////////////
	// Frame start and bit shifting
	////////////////////////////////////////

	always @(negedge spi_cs) begin
		in_frame = 1'b1;
		edge_cnt = 0;
		shift    = '0;
	end

	// Header and write data come in on rising edges
	always @(posedge spi_sck) begin
		if (spi_cs === 1'b0) begin
			sck_rise_t = $realtime;
			assert (mosi_change_t < $realtime)
			else begin
				$display("** Error at %0d ns: MOSI changed on a rising SCK edge", $time);
				err_count++;
			end
			shift = {shift[`SPI_FRAME_W-2:0], spi_mosi};
			edge_cnt++;
		end
	end

	// Read data goes out MSB first once the address is known
	always @(negedge spi_sck) begin
		if (spi_cs === 1'b0 && edge_cnt >= HDR_W && edge_cnt < `SPI_FRAME_W) begin
			if (edge_cnt == HDR_W)
				rd_word = regs[shift[`SPI_ADDR_W-1:0]];
			spi_miso = rd_word[`SPI_FRAME_W-1-edge_cnt];
		end
	end

	////////////////////////////////////////
	// Frame end
	////////////////////////////////////////

	always @(posedge spi_cs) begin
		if (in_frame) begin
			in_frame = 1'b0;
			spi_miso = 1'b0;
			assert (edge_cnt == `SPI_FRAME_W)
			else begin
				$display("** Error at %0d ns: frame had %0d SCK rising edges, expected %0d",
					$time, edge_cnt, `SPI_FRAME_W);
				err_count++;
			end
			last_frame = shift;
			frame_count++;
			if (last_frame.rw == RW_WRITE)
				regs[last_frame.addr] = last_frame.data;
		end
	end

endmodule

// ==== verif/tb_spi_reg_top.sv ====
`timescale 1ns/1ps
`include "spi_defs.svh"

module tb_spi_reg_top
	import spi_pkg::*;
();

	localparam int N_RANDOM    = 40;
	localparam int N_REQ       = 8 + N_RANDOM;
	localparam int ACK_LIMIT   = `SPI_FRAME_W * 4 * `SPI_HALF_DIV;
	localparam int WATCHDOG_NS = (N_REQ + 10) * `SPI_FRAME_W * 2 * `SPI_HALF_DIV * 20 * 2;

	logic                   CLK50MHZ;
	logic                   RST;
	logic                   req;
	logic                   rw;
	logic [`SPI_ADDR_W-1:0] addr;
	logic [`SPI_DATA_W-1:0] wdata;
	logic                   busy;
	logic                   ack;
	logic [`SPI_DATA_W-1:0] rdata;
	logic                   spi_sck;
	logic                   spi_cs;
	logic                   spi_mosi;
	logic                   spi_miso;
	spi_frame_t             model_frame;
	int                     model_frames;
	int                     model_errors;
	int                     errors;
	int                     ack_count;
	int                     accepted_count;
	int                     seed;
	logic [`SPI_DATA_W-1:0] ref_regs [1 << `SPI_ADDR_W];

	spi_reg_top i_dut (
		.CLK50MHZ (CLK50MHZ),
		.RST      (RST),
		.req      (req),
		.rw       (rw),
		.addr     (addr),
		.wdata    (wdata),
		.busy     (busy),
		.ack      (ack),
		.rdata    (rdata),
		.spi_sck  (spi_sck),
		.spi_cs   (spi_cs),
		.spi_mosi (spi_mosi),
		.spi_miso (spi_miso)
	);

	spi_slave_model i_slave (
		.spi_sck     (spi_sck),
		.spi_cs      (spi_cs),
		.spi_mosi    (spi_mosi),
		.spi_miso    (spi_miso),
		.last_frame  (model_frame),
		.frame_count (model_frames),
		.err_count   (model_errors)
	);

	initial CLK50MHZ = 1'b0;
	always #10 CLK50MHZ = ~CLK50MHZ;

	task automatic report_error(input string msg);
		$display("** Error at %0d ns: %s", $time, msg);
		errors++;
	endtask

	task automatic check_idle_outputs();
		assert (spi_cs === 1'b1 && spi_sck === 1'b0 && spi_mosi === 1'b0 &&
			busy === 1'b0 && ack === 1'b0)
		else report_error("outputs not in their idle state");
	endtask

	// One-cycle request driven just after the clock edge
	task automatic issue_req(input logic wr, input logic [`SPI_ADDR_W-1:0] a,
			input logic [`SPI_DATA_W-1:0] d);
		@(posedge CLK50MHZ);
		#1;
		req   = 1'b1;
		rw    = wr;
		addr  = a;
		wdata = d;
		@(posedge CLK50MHZ);
		#1;
		req = 1'b0;
	endtask

	task automatic wait_for_ack(output bit seen);
		int cycles;
		cycles = 0;
		seen   = 1'b0;
		while (!seen && cycles < ACK_LIMIT) begin
			@(negedge CLK50MHZ);
			seen = (ack === 1'b1);
			cycles++;
		end
	endtask

	// Checks the frame the model saw and the read data against the reference
	task automatic finish_access(input logic wr, input logic [`SPI_ADDR_W-1:0] a,
			input logic [`SPI_DATA_W-1:0] d);
		bit seen;
		wait_for_ack(seen);
		if (!seen) begin
			$display("No ack arrived for the request to address 0x%0h", a);
			errors++;
		end else begin
			assert (model_frame.rw == wr && model_frame.addr == a)
			else report_error($sformatf("header rw=%0b addr=0x%0h, expected rw=%0b addr=0x%0h",
				model_frame.rw, model_frame.addr, wr, a));
			if (wr) begin
				assert (model_frame.data == d)
				else report_error($sformatf("write data 0x%06h, expected 0x%06h",
					model_frame.data, d));
				ref_regs[a] = d;
			end else begin
				// Reads carry an all-zero data field on MOSI
				assert (model_frame.data == '0)
				else report_error($sformatf("read frame data 0x%06h, expected zero",
					model_frame.data));
				assert (rdata == ref_regs[a])
				else report_error($sformatf("rdata 0x%06h at 0x%0h, expected 0x%06h",
					rdata, a, ref_regs[a]));
			end
		end
	endtask

	task automatic do_access(input logic wr, input logic [`SPI_ADDR_W-1:0] a,
			input logic [`SPI_DATA_W-1:0] d);
		issue_req(wr, a, d);
		accepted_count++;
		finish_access(wr, a, d);
	endtask

	////////////////////////////////////////
	// Monitors
	////////////////////////////////////////

	always @(negedge CLK50MHZ) begin
		if (RST === 1'b1)
			check_idle_outputs();
	end

	// Each ack comes after exactly one more cs-low window
	always @(negedge CLK50MHZ) begin
		if (RST === 1'b0 && ack === 1'b1) begin
			ack_count++;
			assert (model_frames == ack_count)
			else report_error($sformatf("%0d frames before ack %0d", model_frames, ack_count));
		end
	end

	ack_one_cycle: assert property (@(posedge CLK50MHZ) disable iff (RST) ack |=> !ack)
		else report_error("ack high for more than one cycle");
	busy_after_ack: assert property (@(posedge CLK50MHZ) disable iff (RST) ack |=> !busy)
		else report_error("busy high in the cycle after ack");
	cs_high_at_ack: assert property (@(posedge CLK50MHZ) disable iff (RST) ack |-> spi_cs)
		else report_error("spi_cs low while ack is high");

	////////////////////////////////////////
	// Stimulus
	////////////////////////////////////////

	initial begin
		logic                   rnd_wr;
		logic [`SPI_ADDR_W-1:0] rnd_addr;
		logic [`SPI_DATA_W-1:0] rnd_data;
		seed           = 32'h5815;
		RST            = 1'b1;
		req            = 1'b0;
		rw             = 1'b0;
		addr           = '0;
		wdata          = '0;
		errors         = 0;
		ack_count      = 0;
		accepted_count = 0;
		for (int i = 0; i < (1 << `SPI_ADDR_W); i++)
			ref_regs[i] = '0;

		repeat (8) @(posedge CLK50MHZ);
		#1 RST = 1'b0;
		repeat (3) begin
			@(negedge CLK50MHZ);
			check_idle_outputs();
		end

		// Write, read back, and one address never written
		do_access(1'b1, 7'h05, 24'hA5C30F);
		do_access(1'b1, 7'h7F, 24'h123456);
		do_access(1'b0, 7'h05, '0);
		do_access(1'b0, 7'h7F, '0);
		do_access(1'b0, 7'h22, '0);

		// Second request lands while busy and must vanish
		issue_req(1'b1, 7'h30, 24'hABCDEF);
		accepted_count++;
		repeat (10) @(negedge CLK50MHZ);
		assert (busy === 1'b1) else report_error("busy low during a frame");
		issue_req(1'b1, 7'h31, 24'h00BEEF);
		finish_access(1'b1, 7'h30, 24'hABCDEF);
		repeat (ACK_LIMIT) @(negedge CLK50MHZ);
		assert (model_frames == accepted_count)
		else report_error($sformatf("%0d frames, expected %0d", model_frames, accepted_count));
		do_access(1'b0, 7'h31, '0);

		// Small address range so reads often hit earlier writes
		for (int i = 0; i < N_RANDOM; i++) begin
			rnd_wr   = $random(seed);
			rnd_addr = $random(seed) & 7'h0F;
			rnd_data = $random(seed);
			do_access(rnd_wr, rnd_addr, rnd_data);
		end

		repeat (4) @(negedge CLK50MHZ);
		assert (ack_count == accepted_count)
		else report_error($sformatf("%0d acks, expected %0d", ack_count, accepted_count));
		assert (model_frames == accepted_count)
		else report_error($sformatf("%0d frames, expected %0d", model_frames, accepted_count));

		$display("Errors: %0d in testbench checks, %0d in SPI model", errors, model_errors);
		if (errors == 0 && model_errors == 0)
			$display("Everything OK");
		else
			$display("Something failed");
		$finish;
	end

	initial begin
		#(WATCHDOG_NS);
		$display("Timeout: the run did not finish within %0d ns", WATCHDOG_NS);
		$display("Something failed");
		$finish;
	end

endmodule

// ==== files.f ====
+incdir+include
design/spi_pkg.sv
design/spi_tick_if.sv
design/spi_clk_gen.sv
design/spi_master.sv
design/spi_reg_access.sv
design/spi_reg_top.sv
verif/spi_slave_model.sv
verif/tb_spi_reg_top.sv

// ==== Bender.yml ====
package:
  name: spi_reg_bridge

sources:
  - include_dirs:
      - include
    files:
      - design/spi_pkg.sv
      - design/spi_tick_if.sv
      - design/spi_clk_gen.sv
      - design/spi_master.sv
      - design/spi_reg_access.sv
      - design/spi_reg_top.sv
  - target: test
    include_dirs:
      - include
    files:
      - verif/spi_slave_model.sv
      - verif/tb_spi_reg_top.sv
